/* verilog/matrixEnginePkg.sv */
// Matrix engine shared definitions
// Array geometry, operand and result widths, phase timing
// and the enums for controller states and write targets

package matrixEnginePkg;

    // ==============================
    // Geometry and widths
    // ==============================
    localparam int ARRAY_DIM       = 4;                          // Rows and columns of the array
    localparam int WEIGHT_WIDTH    = 8;                          // Signed weight
    localparam int ACT_WIDTH       = 7;                          // Unsigned activation
    // Signed product fits WEIGHT_WIDTH+ACT_WIDTH bits, plus growth for ARRAY_DIM terms
    localparam int RESULT_WIDTH    = WEIGHT_WIDTH + ACT_WIDTH + $clog2(ARRAY_DIM);
    localparam int ELEM_ADDR_WIDTH = $clog2(ARRAY_DIM * ARRAY_DIM); // row*ARRAY_DIM+col
    localparam int ROW_ADDR_WIDTH  = $clog2(ARRAY_DIM);

    // ==============================
    // Phase timing
    // ==============================
    // Memory read register plus one stage per array row
    localparam int RESULT_LATENCY  = ARRAY_DIM + 1;
    // Last column of the last row lands in the store on the final compute cycle
    localparam int COMPUTE_CYCLES  = 2 * ARRAY_DIM + RESULT_LATENCY - 1;

    // ==============================
    // Enums
    // ==============================
    typedef enum logic [1:0] {
        IDLE,           // Waiting for startReq
        LOAD_WEIGHT,    // Shifting weight rows into the array
        COMPUTE,        // Streaming activations, capturing results
        DONE            // Holding startAck until startReq drops
    } engineState_e;

    typedef enum logic {
        SEL_WEIGHT,
        SEL_ACT
    } memSel_e;

endpackage

/* verilog/operandMemory.sv */
// Operand memory
// Element-wide writes from the host, row-wide registered reads
// toward the array; the read register shows zeros when idle

`timescale 1ns/10ps

module operandMemory #(
    parameter int dataWidth = 8
) (
    input  logic clk,
    input  logic rst,
    input  logic wrEn,
    input  logic [matrixEnginePkg::ELEM_ADDR_WIDTH-1:0] wrAddr,
    input  logic [dataWidth-1:0] wrData,
    input  logic rdEn,
    input  logic [matrixEnginePkg::ROW_ADDR_WIDTH-1:0] rdRow,
    output logic [matrixEnginePkg::ARRAY_DIM*dataWidth-1:0] rdRowData
);

    logic [dataWidth-1:0] mem [matrixEnginePkg::ARRAY_DIM*matrixEnginePkg::ARRAY_DIM];

    always_ff @(posedge clk) begin
        if (wrEn) mem[wrAddr] <= wrData;       // One element per write
    end

    // Lane c of the row comes from element rdRow*DIM+c
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdRowData <= '0;
        end else begin
            for (int c = 0; c < matrixEnginePkg::ARRAY_DIM; c++) begin
                rdRowData[c*dataWidth +: dataWidth] <=
                    rdEn ? mem[{rdRow, matrixEnginePkg::ROW_ADDR_WIDTH'(c)}] : '0; // Zero flushes
            end
        end
    end

endmodule

/* verilog/inputSkew.sv */
// Activation input skew
// Lane i is delayed by i cycles so each row enters the array
// as a diagonal wavefront in step with the partial sums

`timescale 1ns/10ps

module inputSkew (
    input  logic clk,
    input  logic rst,
    input  logic [matrixEnginePkg::ARRAY_DIM*matrixEnginePkg::ACT_WIDTH-1:0] rowIn,
    output logic [matrixEnginePkg::ARRAY_DIM*matrixEnginePkg::ACT_WIDTH-1:0] skewedOut
);

    // Lane 0 has no delay
    assign skewedOut[0 +: matrixEnginePkg::ACT_WIDTH] = rowIn[0 +: matrixEnginePkg::ACT_WIDTH];

    for (genvar i = 1; i < matrixEnginePkg::ARRAY_DIM; i++) begin : laneGen
        logic [matrixEnginePkg::ACT_WIDTH-1:0] dly [i];   // Depth i shift register

        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                for (int d = 0; d < i; d++) dly[d] <= '0;
            end else begin
                dly[0] <= rowIn[i*matrixEnginePkg::ACT_WIDTH +: matrixEnginePkg::ACT_WIDTH];
                for (int d = 1; d < i; d++) dly[d] <= dly[d-1];
            end
        end

        assign skewedOut[i*matrixEnginePkg::ACT_WIDTH +: matrixEnginePkg::ACT_WIDTH] = dly[i-1];
    end

endmodule

/* verilog/processingElement.sv */
// Processing element
// Holds one stationary weight, passes activations right and
// adds weight times activation into the partial sum going down

`timescale 1ns/10ps

module processingElement (
    input  logic clk,
    input  logic rst,
    input  logic signed [matrixEnginePkg::WEIGHT_WIDTH-1:0] weightIn,
    input  logic weightShift,
    input  logic [matrixEnginePkg::ACT_WIDTH-1:0] actIn,
    input  logic signed [matrixEnginePkg::RESULT_WIDTH-1:0] psumIn,
    output logic signed [matrixEnginePkg::WEIGHT_WIDTH-1:0] weightOut,
    output logic [matrixEnginePkg::ACT_WIDTH-1:0] actOut,
    output logic signed [matrixEnginePkg::RESULT_WIDTH-1:0] psumOut
);

    // Activation zero-extended so it multiplies as a positive value
    logic signed [matrixEnginePkg::WEIGHT_WIDTH+matrixEnginePkg::ACT_WIDTH:0] product;

    assign product = weightOut * $signed({1'b0, actIn});

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            weightOut <= '0;
            actOut    <= '0;
            psumOut   <= '0;
        end else begin
            if (weightShift) weightOut <= weightIn;   // Weight chain moves down
            actOut  <= actIn;                         // One stage to the right
            psumOut <= psumIn + product;              // Sign-extended add
        end
    end

endmodule

/* verilog/systolicArray.sv */
// Weight-stationary systolic array
// DIM x DIM processing elements; weights enter at the top and shift down,
// activation lane i enters row i from the left, column sums leave at the bottom

`timescale 1ns/10ps

module systolicArray (
    input  logic clk,
    input  logic rst,
    input  logic [matrixEnginePkg::ARRAY_DIM*matrixEnginePkg::WEIGHT_WIDTH-1:0] weightRow,
    input  logic weightShift,
    input  logic [matrixEnginePkg::ARRAY_DIM*matrixEnginePkg::ACT_WIDTH-1:0] actLanes,
    output logic [matrixEnginePkg::ARRAY_DIM*matrixEnginePkg::RESULT_WIDTH-1:0] psumBottom
);

    // ==============================
    // Grid wiring
    // ==============================
    logic signed [matrixEnginePkg::WEIGHT_WIDTH-1:0]
        weightWire [matrixEnginePkg::ARRAY_DIM+1][matrixEnginePkg::ARRAY_DIM];
    logic [matrixEnginePkg::ACT_WIDTH-1:0]
        actWire [matrixEnginePkg::ARRAY_DIM][matrixEnginePkg::ARRAY_DIM+1];
    logic signed [matrixEnginePkg::RESULT_WIDTH-1:0]
        psumWire [matrixEnginePkg::ARRAY_DIM+1][matrixEnginePkg::ARRAY_DIM];

    for (genvar k = 0; k < matrixEnginePkg::ARRAY_DIM; k++) begin : edgeGen
        assign weightWire[0][k] = weightRow[k*matrixEnginePkg::WEIGHT_WIDTH +:
                                            matrixEnginePkg::WEIGHT_WIDTH];  // Top edge
        assign actWire[k][0]    = actLanes[k*matrixEnginePkg::ACT_WIDTH +:
                                           matrixEnginePkg::ACT_WIDTH];      // Left edge
        assign psumWire[0][k]   = '0;                                        // Sums start at zero
        assign psumBottom[k*matrixEnginePkg::RESULT_WIDTH +: matrixEnginePkg::RESULT_WIDTH] =
            psumWire[matrixEnginePkg::ARRAY_DIM][k];
    end

    // ==============================
    // PE grid
    // ==============================
    for (genvar i = 0; i < matrixEnginePkg::ARRAY_DIM; i++) begin : rowGen
        for (genvar j = 0; j < matrixEnginePkg::ARRAY_DIM; j++) begin : colGen
            processingElement pe (
                .clk         (clk),
                .rst         (rst),
                .weightIn    (weightWire[i][j]),
                .weightShift (weightShift),
                .actIn       (actWire[i][j]),
                .psumIn      (psumWire[i][j]),
                .weightOut   (weightWire[i+1][j]),
                .actOut      (actWire[i][j+1]),
                .psumOut     (psumWire[i+1][j])
            );
        end
    end

endmodule

/* verilog/resultStore.sv */
// Result store
// Staircase write enables de-skew the column outputs so C[t][j]
// lands at element t*DIM+j; registered readback for the host

`timescale 1ns/10ps

module resultStore (
    input  logic clk,
    input  logic rst,
    input  logic [matrixEnginePkg::ARRAY_DIM*matrixEnginePkg::RESULT_WIDTH-1:0] psumBottom,
    input  logic captureStart,
    input  logic [matrixEnginePkg::ELEM_ADDR_WIDTH-1:0] rdAddr,
    output logic signed [matrixEnginePkg::RESULT_WIDTH-1:0] rdData
);

    logic [matrixEnginePkg::ARRAY_DIM-2:0] stairReg;     // Start pulse, one stage per column
    logic [matrixEnginePkg::ARRAY_DIM-1:0] colStart;
    logic [matrixEnginePkg::ROW_ADDR_WIDTH-1:0] rowCnt [matrixEnginePkg::ARRAY_DIM];
    logic signed [matrixEnginePkg::RESULT_WIDTH-1:0]
        results [matrixEnginePkg::ARRAY_DIM*matrixEnginePkg::ARRAY_DIM];

    assign colStart = {stairReg, captureStart};          // Column j starts j cycles late

    // ==============================
    // Capture
    // ==============================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stairReg <= '0;
            rdData   <= '0;
            for (int j = 0; j < matrixEnginePkg::ARRAY_DIM; j++) rowCnt[j] <= '0;
            for (int e = 0; e < matrixEnginePkg::ARRAY_DIM**2; e++) results[e] <= '0;
        end else begin
            stairReg <= colStart[matrixEnginePkg::ARRAY_DIM-2:0];
            for (int j = 0; j < matrixEnginePkg::ARRAY_DIM; j++) begin
                // Busy from the start pulse until the row counter wraps
                if (colStart[j] || rowCnt[j] != '0) begin
                    results[{rowCnt[j], matrixEnginePkg::ROW_ADDR_WIDTH'(j)}] <=
                        psumBottom[j*matrixEnginePkg::RESULT_WIDTH +: matrixEnginePkg::RESULT_WIDTH];
                    rowCnt[j] <= rowCnt[j] + 1'b1;
                end
            end
            rdData <= results[rdAddr];                    // One-cycle read
        end
    end

endmodule

/* verilog/engineController.sv */
// Engine run sequencer
// Owns the start handshake, walks through weight load and compute,
// and issues every memory read and pipeline strobe of a run

`timescale 1ns/10ps

module engineController (
    input  logic clk,
    input  logic rst,
    input  logic startReq,
    output logic startAck,
    output logic weightRdEn,
    output logic [matrixEnginePkg::ROW_ADDR_WIDTH-1:0] weightRdRow,
    output logic actRdEn,
    output logic [matrixEnginePkg::ROW_ADDR_WIDTH-1:0] actRdRow,
    output logic weightShift,
    output logic captureStart
);

    matrixEnginePkg::engineState_e state;
    logic [$clog2(matrixEnginePkg::COMPUTE_CYCLES)-1:0] cycleCnt;   // Cycle within a phase

    // ==============================
    // State machine
    // ==============================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= matrixEnginePkg::IDLE;
            cycleCnt <= '0;
            startAck <= 1'b0;
        end else begin
            case (state)
                matrixEnginePkg::IDLE: begin
                    if (startReq) state <= matrixEnginePkg::LOAD_WEIGHT;
                end
                matrixEnginePkg::LOAD_WEIGHT: begin
                    if (cycleCnt == matrixEnginePkg::ARRAY_DIM) begin    // Reads plus last shift
                        state    <= matrixEnginePkg::COMPUTE;
                        cycleCnt <= '0;
                    end else begin
                        cycleCnt <= cycleCnt + 1'b1;
                    end
                end
                matrixEnginePkg::COMPUTE: begin
                    if (cycleCnt == matrixEnginePkg::COMPUTE_CYCLES - 1) begin
                        state    <= matrixEnginePkg::DONE;
                        cycleCnt <= '0;
                    end else begin
                        cycleCnt <= cycleCnt + 1'b1;
                    end
                end
                matrixEnginePkg::DONE: begin
                    // Ack follows the request; dropping it closes the handshake
                    startAck <= startReq;
                    if (!startReq) state <= matrixEnginePkg::IDLE;
                end
                default: state <= matrixEnginePkg::IDLE;
            endcase
        end
    end

    // ==============================
    // Strobe decode
    // ==============================
    // Weight rows go last to first so row 0 ends up at the top of the array
    assign weightRdEn  = (state == matrixEnginePkg::LOAD_WEIGHT) &&
                         (cycleCnt < matrixEnginePkg::ARRAY_DIM);
    assign weightRdRow = ~cycleCnt[matrixEnginePkg::ROW_ADDR_WIDTH-1:0];  // DIM-1-cnt, DIM is 2^n
    assign weightShift = (state == matrixEnginePkg::LOAD_WEIGHT) && (cycleCnt != '0); // Read + 1

    // Activation rows 0..DIM-1 on the first compute cycles
    assign actRdEn      = (state == matrixEnginePkg::COMPUTE) &&
                          (cycleCnt < matrixEnginePkg::ARRAY_DIM);
    assign actRdRow     = cycleCnt[matrixEnginePkg::ROW_ADDR_WIDTH-1:0];
    assign captureStart = (state == matrixEnginePkg::COMPUTE) &&
                          (cycleCnt == matrixEnginePkg::RESULT_LATENCY);  // Row 0, column 0 at bottom

endmodule

/* verilog/matrixEngine.sv */
// Weight-stationary matrix engine, top level
// Host loads W and A element by element, starts a run with a
// four-phase handshake and reads back C = A x W afterwards

`timescale 1ns/10ps

module matrixEngine (
    input  logic clk,
    input  logic rst,
    input  logic wrEn,
    input  matrixEnginePkg::memSel_e wrSel,
    input  logic [matrixEnginePkg::ELEM_ADDR_WIDTH-1:0] wrAddr,
    input  logic [matrixEnginePkg::WEIGHT_WIDTH-1:0] wrData,   // Activations use low bits
    input  logic startReq,
    output logic startAck,
    input  logic [matrixEnginePkg::ELEM_ADDR_WIDTH-1:0] rdAddr,
    output logic signed [matrixEnginePkg::RESULT_WIDTH-1:0] rdData
);

    // ==============================
    // Internal nets
    // ==============================
    logic weightWrEn;
    logic actWrEn;
    logic weightRdEn;
    logic actRdEn;
    logic weightShift;
    logic captureStart;
    logic [matrixEnginePkg::ROW_ADDR_WIDTH-1:0] weightRdRow;
    logic [matrixEnginePkg::ROW_ADDR_WIDTH-1:0] actRdRow;
    logic [matrixEnginePkg::ARRAY_DIM*matrixEnginePkg::WEIGHT_WIDTH-1:0] weightRowData;
    logic [matrixEnginePkg::ARRAY_DIM*matrixEnginePkg::ACT_WIDTH-1:0] actRowData;
    logic [matrixEnginePkg::ARRAY_DIM*matrixEnginePkg::ACT_WIDTH-1:0] skewedAct;
    logic [matrixEnginePkg::ARRAY_DIM*matrixEnginePkg::RESULT_WIDTH-1:0] psumBottom;

    assign weightWrEn = wrEn && (wrSel == matrixEnginePkg::SEL_WEIGHT);
    assign actWrEn    = wrEn && (wrSel == matrixEnginePkg::SEL_ACT);

    engineController ctrl (
        .clk(clk), .rst(rst), .startReq(startReq), .startAck(startAck),
        .weightRdEn(weightRdEn), .weightRdRow(weightRdRow),
        .actRdEn(actRdEn), .actRdRow(actRdRow),
        .weightShift(weightShift), .captureStart(captureStart)
    );

    operandMemory #(.dataWidth(matrixEnginePkg::WEIGHT_WIDTH)) weightMem (
        .clk(clk), .rst(rst), .wrEn(weightWrEn), .wrAddr(wrAddr), .wrData(wrData),
        .rdEn(weightRdEn), .rdRow(weightRdRow), .rdRowData(weightRowData)
    );

    operandMemory #(.dataWidth(matrixEnginePkg::ACT_WIDTH)) actMem (
        .clk(clk), .rst(rst), .wrEn(actWrEn), .wrAddr(wrAddr),
        .wrData(wrData[matrixEnginePkg::ACT_WIDTH-1:0]),
        .rdEn(actRdEn), .rdRow(actRdRow), .rdRowData(actRowData)
    );

    inputSkew skew (.clk(clk), .rst(rst), .rowIn(actRowData), .skewedOut(skewedAct));

    systolicArray array (
        .clk(clk), .rst(rst), .weightRow(weightRowData), .weightShift(weightShift),
        .actLanes(skewedAct), .psumBottom(psumBottom)
    );

    resultStore store (
        .clk(clk), .rst(rst), .psumBottom(psumBottom), .captureStart(captureStart),
        .rdAddr(rdAddr), .rdData(rdData)
    );

endmodule

/* dv/matrixEngine_checker.sv */
// Matrix engine protocol checker
// Bound to the top level; watches the start handshake and the
// rule that the host writes operands only between runs

`timescale 1ns/10ps

module matrixEngine_checker (
    input logic clk,
    input logic rst,
    input logic wrEn,
    input logic startReq,
    input logic startAck
);

    int errorCount = 0;     // Failed assertions so far

    // Ack rises only in answer to a request
    ackNeedsReq: assert property (@(posedge clk) disable iff (rst)
        $rose(startAck) |-> $past(startReq))
        else begin errorCount++; $error("startAck rose without startReq"); end

    // Ack is held for as long as the request stays up
    ackHolds: assert property (@(posedge clk) disable iff (rst)
        (startReq && startAck) |=> startAck)
        else begin errorCount++; $error("startAck dropped while startReq high"); end

    // Operand writes only while the handshake is idle
    noWriteInRun: assert property (@(posedge clk) disable iff (rst)
        !(wrEn && (startReq || startAck)))
        else begin errorCount++; $error("wrEn high during a run"); end

    ackLowInReset: assert property (@(posedge clk) rst |-> !startAck)
        else begin errorCount++; $error("startAck high during reset"); end

endmodule

/* dv/matrixEngineTb.sv */
// Matrix engine testbench
// Loads W and A from the vector file, runs the engine through the
// start handshake and checks every element of C on readback

`timescale 1ns/10ps

module matrixEngineTb;

    // ==============================
    // Constants and signals
    // ==============================
    localparam int CLK_PERIOD = 8;
    localparam int NUM_TESTS  = 4;
    localparam int ELEMS      = matrixEnginePkg::ARRAY_DIM * matrixEnginePkg::ARRAY_DIM;
    localparam int TEST_WORDS = 1 + 3 * ELEMS;             // Code, W, A, C
    localparam int RUN_CYCLES = matrixEnginePkg::ARRAY_DIM + 1 +
                                matrixEnginePkg::COMPUTE_CYCLES + 1;
    // Writes, run, two full readbacks at 2 cycles per element, hold and gaps
    localparam int TEST_CYCLES = 2 * ELEMS + RUN_CYCLES + 4 * ELEMS + 60;
    localparam int WATCHDOG_CYCLES = 5 + 2 * ELEMS + NUM_TESTS * TEST_CYCLES + 20;

    logic clk;
    logic rst;
    logic wrEn;
    matrixEnginePkg::memSel_e wrSel;
    logic [matrixEnginePkg::ELEM_ADDR_WIDTH-1:0] wrAddr;
    logic [matrixEnginePkg::WEIGHT_WIDTH-1:0] wrData;
    logic startReq;
    logic startAck;
    logic [matrixEnginePkg::ELEM_ADDR_WIDTH-1:0] rdAddr;
    logic signed [matrixEnginePkg::RESULT_WIDTH-1:0] rdData;

    logic [19:0] vecMem [NUM_TESTS*TEST_WORDS];             // Raw vector words
    logic signed [matrixEnginePkg::WEIGHT_WIDTH-1:0] weights [ELEMS];
    logic [matrixEnginePkg::ACT_WIDTH-1:0] acts [ELEMS];
    logic signed [matrixEnginePkg::RESULT_WIDTH-1:0] expected [ELEMS];
    logic [matrixEnginePkg::ACT_WIDTH-1:0] loadedActs [ELEMS];  // Contents of actMem
    bit actsLoaded = 1'b0;

    matrixEngine uut (
        .clk(clk), .rst(rst), .wrEn(wrEn), .wrSel(wrSel), .wrAddr(wrAddr),
        .wrData(wrData), .startReq(startReq), .startAck(startAck),
        .rdAddr(rdAddr), .rdData(rdData)
    );

    bind matrixEngine matrixEngine_checker handshakeChecks (
        .clk(clk), .rst(rst), .wrEn(wrEn), .startReq(startReq), .startAck(startAck)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d clock cycles, the engine never finished",
                 WATCHDOG_CYCLES);
        $display("test failed");
        $fatal(1, "Timeout");
    end

    // Stop at the first assertion failure from the bound checker
    always @(negedge clk) begin
        if (uut.handshakeChecks.errorCount != 0) begin
            $display("A handshake or write rule assertion failed");
            $display("test failed");
            $fatal(1, "Assertion failure");
        end
    end

    // ==============================
    // Helpers
    // ==============================
    task automatic checkValue(input string testName, input logic signed [31:0] expVal,
                              input logic signed [31:0] actVal);
        if (expVal !== actVal) begin
            $display("Error in %s: expected %0d, actual %0d", testName, expVal, actVal);
            $display("test failed");
            $fatal(1, "Mismatch");
        end
    endtask

    function automatic string testName(input logic [19:0] code);
        case (code)
            20'h1:   return "identity";
            20'h2:   return "extremes";
            20'h3:   return "weightReload";
            20'h4:   return "mixed";
            default: return "unknown";
        endcase
    endfunction

    // C[row][col] = sum over k of A[row][k] * W[k][col]
    function automatic int computeResult(input int row, input int col);
        int sum;
        sum = 0;
        for (int k = 0; k < matrixEnginePkg::ARRAY_DIM; k++)
            sum += int'(weights[k*matrixEnginePkg::ARRAY_DIM+col]) *
                   int'(acts[row*matrixEnginePkg::ARRAY_DIM+k]);
        return sum;
    endfunction

    task automatic idleGap();
        repeat ($urandom % 4) @(negedge clk);
    endtask

    task automatic writeElement(input matrixEnginePkg::memSel_e sel, input int addr,
                                input logic [7:0] data);
        @(negedge clk);
        wrEn   = 1'b1;
        wrSel  = sel;
        wrAddr = matrixEnginePkg::ELEM_ADDR_WIDTH'(addr);
        wrData = data;
    endtask

    task automatic endWrites();
        @(negedge clk);
        wrEn = 1'b0;
    endtask

    task automatic startRun(input string name);
        @(negedge clk);
        checkValue({name, " ack before start"}, 0, startAck);
        startReq = 1'b1;
        while (startAck !== 1'b1) @(negedge clk);    // Watchdog bounds this wait
    endtask

    // rdData is registered, so it is sampled one cycle after rdAddr
    task automatic readAll(input string name);
        for (int e = 0; e < ELEMS; e++) begin
            @(negedge clk);
            rdAddr = matrixEnginePkg::ELEM_ADDR_WIDTH'(e);
            @(negedge clk);
            checkValue($sformatf("%s C[%0d][%0d]", name, e / matrixEnginePkg::ARRAY_DIM,
                       e % matrixEnginePkg::ARRAY_DIM), expected[e], rdData);
        end
    endtask

    task automatic holdAndRelease(input string name);
        repeat (3) begin                                 // Extra hold beyond readback
            @(negedge clk);
            checkValue({name, " ack hold"}, 1, startAck);
        end
        startReq = 1'b0;
        @(negedge clk);
        checkValue({name, " ack release"}, 0, startAck); // Falls one cycle later
    endtask

    task automatic runTest(input int t);
        int base;
        string name;
        bit writeActs;
        base = t * TEST_WORDS;
        name = testName(vecMem[base]);
        for (int e = 0; e < ELEMS; e++) begin
            weights[e]  = vecMem[base+1+e][matrixEnginePkg::WEIGHT_WIDTH-1:0];
            acts[e]     = vecMem[base+1+ELEMS+e][matrixEnginePkg::ACT_WIDTH-1:0];
            expected[e] = vecMem[base+1+2*ELEMS+e][matrixEnginePkg::RESULT_WIDTH-1:0];
        end
        // File results against the matrix product rule
        for (int e = 0; e < ELEMS; e++)
            checkValue({name, " vector file"}, computeResult(e / matrixEnginePkg::ARRAY_DIM,
                       e % matrixEnginePkg::ARRAY_DIM), expected[e]);
        idleGap();
        for (int e = 0; e < ELEMS; e++)
            writeElement(matrixEnginePkg::SEL_WEIGHT, e, weights[e]);
        // Activations already in actMem are kept, which exercises retention
        writeActs = !actsLoaded;
        for (int e = 0; e < ELEMS; e++)
            if (acts[e] !== loadedActs[e]) writeActs = 1'b1;
        if (writeActs) begin
            for (int e = 0; e < ELEMS; e++) begin
                writeElement(matrixEnginePkg::SEL_ACT, e, {1'b0, acts[e]});
                loadedActs[e] = acts[e];
            end
            actsLoaded = 1'b1;
        end
        endWrites();
        idleGap();
        startRun(name);
        readAll(name);                                   // While startAck is high
        holdAndRelease(name);
        idleGap();
        readAll({name, " reread"});
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        void'($urandom(46));
        rst      = 1'b1;
        wrEn     = 1'b0;
        wrSel    = matrixEnginePkg::SEL_WEIGHT;
        wrAddr   = '0;
        wrData   = '0;
        startReq = 1'b0;
        rdAddr   = '0;
        $readmemh("dv/matrixEngine_vectors.txt", vecMem);
        if ($isunknown(vecMem[0]) || $isunknown(vecMem[NUM_TESTS*TEST_WORDS-1])) begin
            $display("Vector file is missing or shorter than %0d tests", NUM_TESTS);
            $display("test failed");
            $fatal(1, "No vectors");
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Reset state: no ack, empty result store
        checkValue("reset ack", 0, startAck);
        for (int e = 0; e < ELEMS; e++) expected[e] = '0;
        readAll("reset");

        for (int t = 0; t < NUM_TESTS; t++) runTest(t);

        @(negedge clk);
        if (uut.handshakeChecks.errorCount == 0) begin
            $display("test passed");
            $finish;
        end else begin
            $display("Assertion failures: %0d", uut.handshakeChecks.errorCount);
            $display("test failed");
            $fatal(1, "Assertion failure");
        end
    end

endmodule

/* matrixEngine.f */
verilog/matrixEnginePkg.sv
verilog/operandMemory.sv
verilog/inputSkew.sv
verilog/processingElement.sv
verilog/systolicArray.sv
verilog/resultStore.sv
verilog/engineController.sv
verilog/matrixEngine.sv
dv/matrixEngine_checker.sv
dv/matrixEngineTb.sv

/* dv/matrixEngine_vectors.txt */
// Per test, line 1: test code, 16 weights W[k][j], 16 activations A[t][k], row-major hex
// Line 2: 16 expected results C[t][j], 17-bit two's complement hex, row-major
// Codes: 1 identity, 2 extremes, 3 weightReload (activations kept), 4 mixed
01 01 00 00 00 00 01 00 00 00 00 01 00 00 00 00 01 12 7F 3A 05 40 00 1B 66 2C 71 09 5E 7E 33 48 17
00012 0007F 0003A 00005 00040 00000 0001B 00066 0002C 00071 00009 0005E 0007E 00033 00048 00017
02 80 7F 80 7F 80 7F 7F 80 80 7F 80 00 80 7F 7F 01 7F 7F 7F 7F 7F 7F 7F 7F 7F 00 7F 00 00 7F 00 7F
10200 0FC04 1FF02 00000 10200 0FC04 1FF02 00000 18100 07E02 18100 03F01 18100 07E02 07E02 1C0FF
03 01 02 FF 00 03 FE 00 10 05 00 01 F0 00 04 02 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 00 7F 00 00 7F 00 7F
00477 001FC 000FE 03F01 00477 001FC 000FE 03F01 002FA 000FE 00000 1F810 0017D 000FE 000FE 046F1
04 03 FD 00 0A FF 02 05 00 00 01 FE 04 02 00 03 FF 01 02 03 04 10 00 20 05 7F 01 00 02 00 33 11 08
00009 00004 00010 00012 0003A 1FFF0 1FFCF 0011B 00180 1FE85 0000B 004F4 1FFDD 00077 000F5 0003C
